/* verilog/int_exec_pkg.sv */
`default_nettype none

package int_exec_pkg;

    // number of architectural integer registers
    localparam int NUM_REGS = 32;

    // full data word, also used for pc values
    typedef logic [63:0] xlen_t;

    // lower half of a word, used by the 32-bit word mode
    typedef logic [31:0] word_t;

    // register index
    typedef logic [4:0] reg_addr_t;

    // shift amount for shift-and-add, 0 to 3
    typedef logic [1:0] sll_t;

    // operation selected on the issue port
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SLT    = 4'd1,
        OP_CMP    = 4'd2,
        OP_BRANCH = 4'd3,
        OP_JAL    = 4'd4,
        OP_JALR   = 4'd5,
        OP_AND    = 4'd6,
        OP_OR     = 4'd7,
        OP_XOR    = 4'd8,
        OP_SLA    = 4'd9
    } exec_op_e;

    // true for operations handled by the arithmetic unit
    function automatic logic op_is_arith(exec_op_e op);
        return op inside {OP_ADD, OP_SLT, OP_CMP, OP_BRANCH, OP_JAL, OP_JALR};
    endfunction

    // true for operations handled by the logic unit
    function automatic logic op_is_logic(exec_op_e op);
        return op inside {OP_AND, OP_OR, OP_XOR, OP_SLA};
    endfunction

endpackage

`default_nettype wire

/* verilog/int_arith.sv */
`timescale 1ns/100ps
`default_nettype none

// add/sub, set-less-than, min/max and branch resolution, one cycle
module int_arith
    import int_exec_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire            i_valid,
    input  wire exec_op_e  i_op,
    input  wire xlen_t     i_op1,
    input  wire xlen_t     i_op2,
    input  wire reg_addr_t i_rd,
    // pc of this instruction, base for taken conditional branches
    input  wire xlen_t     i_pc_rdata,
    // pc of the next instruction, fall-through target and link value
    input  wire xlen_t     i_pc_wdata,
    input  wire xlen_t     i_branch_offset,
    input  wire            i_sub,
    input  wire            i_unsigned,
    // min when set, max otherwise
    input  wire            i_cmp_mode,
    input  wire            i_branch_equal,
    input  wire            i_branch_invert,
    input  wire            i_word,
    output logic           o_valid,
    output logic           o_wen,
    output xlen_t          o_result,
    output reg_addr_t      o_rd,
    output logic           o_branch,
    output xlen_t          o_branch_target
);
    logic        claim;
    logic        is_cmp_op;
    logic        is_branch_op;
    logic        do_sub;
    logic        word_mode;
    logic [64:0] add_op1;
    logic [64:0] add_op2;
    logic [64:0] sum;
    word_t       sum_lo;
    xlen_t       add_result;
    logic        lt;
    logic        eq;
    logic        taken;
    xlen_t       result;
    xlen_t       target;

    // only arithmetic-class operations are taken by this unit
    assign claim        = i_valid && op_is_arith(i_op);
    assign is_cmp_op    = (i_op == OP_SLT) || (i_op == OP_CMP) || (i_op == OP_BRANCH);
    assign is_branch_op = (i_op == OP_BRANCH) || (i_op == OP_JAL) || (i_op == OP_JALR);

    // compares always subtract, jumps always add
    assign do_sub    = (i_op == OP_ADD) ? i_sub : is_cmp_op;
    assign word_mode = i_word && (i_op == OP_ADD);

    // 65-bit adder, sign or zero extended so bit 64 is a valid less-than
    assign add_op1 = {i_op1[63] & ~i_unsigned, i_op1};
    assign add_op2 = {i_op2[63] & ~i_unsigned, i_op2} ^ {65{do_sub}};
    assign sum     = add_op1 + add_op2 + {64'd0, do_sub};

    // word mode sign extends the low half of the sum
    assign sum_lo     = sum[31:0];
    assign add_result = word_mode ? {{32{sum_lo[31]}}, sum_lo} : sum[63:0];

    assign lt = sum[64];
    assign eq = (i_op1 == i_op2);

    // eq/ne/lt/ge picked by equal and invert flags
    assign taken = is_branch_op && ((i_branch_equal ? eq : lt) ^ i_branch_invert);

    always_comb begin
        result = '0;
        case (i_op)
            OP_ADD:  result = add_result;
            OP_SLT:  result = {63'd0, lt};
            // op2 wins when it is the smaller for min or the larger for max
            OP_CMP:  result = (lt ^ i_cmp_mode) ? i_op2 : i_op1;
            OP_JAL:  result = i_pc_wdata;
            OP_JALR: result = i_pc_wdata;
            default: result = '0;
        endcase
    end

    always_comb begin
        target = '0;
        case (i_op)
            OP_BRANCH: target = taken ? (i_pc_rdata + i_branch_offset) : i_pc_wdata;
            OP_JAL:    target = add_result;
            // jalr target has bit 0 cleared
            OP_JALR:   target = {add_result[63:1], 1'b0};
            default:   target = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid         <= 1'b0;
            o_wen           <= 1'b0;
            o_result        <= '0;
            o_rd            <= '0;
            o_branch        <= 1'b0;
            o_branch_target <= '0;
        end else begin
            o_valid         <= claim;
            // conditional branches write no register
            o_wen           <= claim && (i_op != OP_BRANCH);
            o_result        <= result;
            o_rd            <= i_rd;
            o_branch        <= claim && taken;
            o_branch_target <= target;
        end
    end

endmodule

`default_nettype wire

/* verilog/int_logic.sv */
`timescale 1ns/100ps
`default_nettype none

// bitwise logic and shift-and-add, one cycle
module int_logic
    import int_exec_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire            i_valid,
    input  wire exec_op_e  i_op,
    input  wire xlen_t     i_op1,
    input  wire xlen_t     i_op2,
    input  wire reg_addr_t i_rd,
    // invert op2 for andn, orn and xnor
    input  wire            i_invert,
    // left shift of op1 before the add in OP_SLA
    input  wire sll_t      i_sll,
    output logic           o_valid,
    output xlen_t          o_result,
    output reg_addr_t      o_rd
);
    logic  claim;
    xlen_t op2_inv;
    xlen_t op1_shifted;
    xlen_t result;

    assign claim = i_valid && op_is_logic(i_op);

    assign op2_inv = i_op2 ^ {64{i_invert}};

    // scaled index plus base, address generation
    assign op1_shifted = i_op1 << i_sll;

    always_comb begin
        result = '0;
        case (i_op)
            OP_AND:  result = i_op1 & op2_inv;
            OP_OR:   result = i_op1 | op2_inv;
            OP_XOR:  result = i_op1 ^ op2_inv;
            // invert does not apply to the shift-add
            OP_SLA:  result = op1_shifted + i_op2;
            default: result = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid  <= 1'b0;
            o_result <= '0;
            o_rd     <= '0;
        end else begin
            o_valid  <= claim;
            o_result <= result;
            o_rd     <= i_rd;
        end
    end

endmodule

`default_nettype wire

/* verilog/int_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

// merges the unit outputs into one registered writeback
module int_writeback
    import int_exec_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire            i_arith_valid,
    input  wire            i_arith_wen,
    input  wire xlen_t     i_arith_result,
    input  wire reg_addr_t i_arith_rd,
    input  wire            i_arith_branch,
    input  wire xlen_t     i_arith_target,
    input  wire            i_logic_valid,
    input  wire xlen_t     i_logic_result,
    input  wire reg_addr_t i_logic_rd,
    output logic           o_wb_valid,
    output logic           o_wb_wen,
    output reg_addr_t      o_wb_rd,
    output xlen_t          o_wb_data,
    output logic           o_branch,
    output xlen_t          o_branch_target
);
    logic      sel_wen;
    reg_addr_t sel_rd;
    xlen_t     sel_data;

    // op classes are disjoint, so at most one valid is high
    always_comb begin
        sel_wen  = 1'b0;
        sel_rd   = '0;
        sel_data = '0;
        if (i_arith_valid) begin
            sel_wen  = i_arith_wen;
            sel_rd   = i_arith_rd;
            sel_data = i_arith_result;
        end else if (i_logic_valid) begin
            // logic results always write
            sel_wen  = 1'b1;
            sel_rd   = i_logic_rd;
            sel_data = i_logic_result;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_valid      <= 1'b0;
            o_wb_wen        <= 1'b0;
            o_wb_rd         <= '0;
            o_wb_data       <= '0;
            o_branch        <= 1'b0;
            o_branch_target <= '0;
        end else begin
            o_wb_valid      <= i_arith_valid || i_logic_valid;
            o_wb_wen        <= sel_wen;
            o_wb_rd         <= sel_rd;
            o_wb_data       <= sel_data;
            // branch info only comes from the arithmetic unit
            o_branch        <= i_arith_valid && i_arith_branch;
            o_branch_target <= i_arith_valid ? i_arith_target : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/int_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

// 32 x 64 register file, one write port, two registered read ports
module int_regfile
    import int_exec_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire            i_wen,
    input  wire reg_addr_t i_waddr,
    input  wire xlen_t     i_wdata,
    input  wire reg_addr_t i_rs1_addr,
    input  wire reg_addr_t i_rs2_addr,
    output xlen_t          o_rs1_rdata,
    output xlen_t          o_rs2_rdata
);
    xlen_t regs [NUM_REGS];
    logic  wr_active;
    logic  rs1_fwd;
    logic  rs2_fwd;

    // register 0 is never written, so it stays at its reset value of zero
    assign wr_active = i_wen && (i_waddr != '0);

    // same-edge write to the address being read
    assign rs1_fwd = wr_active && (i_rs1_addr == i_waddr);
    assign rs2_fwd = wr_active && (i_rs2_addr == i_waddr);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_active) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // read data lands one edge after the address, new data wins on a hit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rs1_rdata <= '0;
            o_rs2_rdata <= '0;
        end else begin
            o_rs1_rdata <= rs1_fwd ? i_wdata : regs[i_rs1_addr];
            o_rs2_rdata <= rs2_fwd ? i_wdata : regs[i_rs2_addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/int_exec_top.sv */
`timescale 1ns/100ps
`default_nettype none

// two-stage integer execute cluster feeding the register file
module int_exec_top
    import int_exec_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_rst_n,
    // issue port, operands already resolved
    input  wire            i_valid,
    input  wire exec_op_e  i_op,
    input  wire xlen_t     i_op1,
    input  wire xlen_t     i_op2,
    input  wire reg_addr_t i_rd,
    input  wire xlen_t     i_pc_rdata,
    input  wire xlen_t     i_pc_wdata,
    input  wire xlen_t     i_branch_offset,
    input  wire            i_sub,
    input  wire            i_unsigned,
    input  wire            i_cmp_mode,
    input  wire            i_branch_equal,
    input  wire            i_branch_invert,
    input  wire            i_word,
    input  wire            i_invert,
    input  wire sll_t      i_sll,
    // register file read ports
    input  wire reg_addr_t i_rs1_addr,
    input  wire reg_addr_t i_rs2_addr,
    output xlen_t          o_rs1_rdata,
    output xlen_t          o_rs2_rdata,
    // writeback, two cycles after issue
    output logic           o_wb_valid,
    output reg_addr_t      o_wb_rd,
    output xlen_t          o_wb_data,
    output logic           o_wb_wen,
    output logic           o_branch,
    output xlen_t          o_branch_target
);
    // stage one to stage two
    logic      arith_valid;
    logic      arith_wen;
    xlen_t     arith_result;
    reg_addr_t arith_rd;
    logic      arith_branch;
    xlen_t     arith_target;
    logic      logic_valid;
    xlen_t     logic_result;
    reg_addr_t logic_rd;

    int_arith u_arith (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (i_valid),
        .i_op            (i_op),
        .i_op1           (i_op1),
        .i_op2           (i_op2),
        .i_rd            (i_rd),
        .i_pc_rdata      (i_pc_rdata),
        .i_pc_wdata      (i_pc_wdata),
        .i_branch_offset (i_branch_offset),
        .i_sub           (i_sub),
        .i_unsigned      (i_unsigned),
        .i_cmp_mode      (i_cmp_mode),
        .i_branch_equal  (i_branch_equal),
        .i_branch_invert (i_branch_invert),
        .i_word          (i_word),
        .o_valid         (arith_valid),
        .o_wen           (arith_wen),
        .o_result        (arith_result),
        .o_rd            (arith_rd),
        .o_branch        (arith_branch),
        .o_branch_target (arith_target)
    );

    int_logic u_logic (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_op1    (i_op1),
        .i_op2    (i_op2),
        .i_rd     (i_rd),
        .i_invert (i_invert),
        .i_sll    (i_sll),
        .o_valid  (logic_valid),
        .o_result (logic_result),
        .o_rd     (logic_rd)
    );

    int_writeback u_writeback (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_arith_valid   (arith_valid),
        .i_arith_wen     (arith_wen),
        .i_arith_result  (arith_result),
        .i_arith_rd      (arith_rd),
        .i_arith_branch  (arith_branch),
        .i_arith_target  (arith_target),
        .i_logic_valid   (logic_valid),
        .i_logic_result  (logic_result),
        .i_logic_rd      (logic_rd),
        .o_wb_valid      (o_wb_valid),
        .o_wb_wen        (o_wb_wen),
        .o_wb_rd         (o_wb_rd),
        .o_wb_data       (o_wb_data),
        .o_branch        (o_branch),
        .o_branch_target (o_branch_target)
    );

    // write port fed straight from the registered writeback
    int_regfile u_regfile (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wen       (o_wb_wen),
        .i_waddr     (o_wb_rd),
        .i_wdata     (o_wb_data),
        .i_rs1_addr  (i_rs1_addr),
        .i_rs2_addr  (i_rs2_addr),
        .o_rs1_rdata (o_rs1_rdata),
        .o_rs2_rdata (o_rs2_rdata)
    );

endmodule

`default_nettype wire

/* dv/tb_int_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_int_exec
    import int_exec_pkg::*;
();
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 3;
    localparam int N_IDLE       = 8;
    localparam int N_ARITH      = 300;
    localparam int N_LOGIC      = 300;
    localparam int N_BRANCH     = 300;
    localparam int N_B2B        = 400;
    localparam int NUM_TESTS    = 5;
    localparam int TOTAL_CYCLES = RESET_CYCLES + N_IDLE + N_ARITH + N_LOGIC + N_BRANCH + N_B2B
                                  + NUM_TESTS * DRAIN_CYCLES;
    // extra 100 cycles of slack on top of the test length
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_valid;
    exec_op_e  i_op;
    xlen_t     i_op1, i_op2, i_pc_rdata, i_pc_wdata, i_branch_offset;
    reg_addr_t i_rd, i_rs1_addr, i_rs2_addr;
    logic      i_sub, i_unsigned, i_cmp_mode, i_branch_equal, i_branch_invert, i_word;
    logic      i_invert;
    sll_t      i_sll;
    xlen_t     o_rs1_rdata, o_rs2_rdata, o_wb_data, o_branch_target;
    reg_addr_t o_wb_rd;
    logic      o_wb_valid, o_wb_wen, o_branch;

    // stimulus source state
    logic [31:0] lfsr;

    // reference register file and the write the DUT does on the coming edge
    xlen_t     model_regs [NUM_REGS];
    logic      wr_pend_en;
    reg_addr_t wr_pend_rd;
    xlen_t     wr_pend_data;

    // expected writeback of the newest issue, then a 2-deep pipe of older ones
    logic      e_valid, e_wen, e_branch, e_is_br;
    reg_addr_t e_rd;
    xlen_t     e_data, e_target;
    logic      p_valid [0:1];
    logic      p_wen [0:1];
    logic      p_branch [0:1];
    logic      p_is_br [0:1];
    reg_addr_t p_rd [0:1];
    xlen_t     p_data [0:1];
    xlen_t     p_target [0:1];

    // read addresses driven this cycle and the ones whose data is due now
    reg_addr_t rs1_new, rs2_new, rs1_prev, rs2_prev;

    int checks;
    int errors;
    int tests;

    int_exec_top u_dut (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (i_valid),
        .i_op            (i_op),
        .i_op1           (i_op1),
        .i_op2           (i_op2),
        .i_rd            (i_rd),
        .i_pc_rdata      (i_pc_rdata),
        .i_pc_wdata      (i_pc_wdata),
        .i_branch_offset (i_branch_offset),
        .i_sub           (i_sub),
        .i_unsigned      (i_unsigned),
        .i_cmp_mode      (i_cmp_mode),
        .i_branch_equal  (i_branch_equal),
        .i_branch_invert (i_branch_invert),
        .i_word          (i_word),
        .i_invert        (i_invert),
        .i_sll           (i_sll),
        .i_rs1_addr      (i_rs1_addr),
        .i_rs2_addr      (i_rs2_addr),
        .o_rs1_rdata     (o_rs1_rdata),
        .o_rs2_rdata     (o_rs2_rdata),
        .o_wb_valid      (o_wb_valid),
        .o_wb_rd         (o_wb_rd),
        .o_wb_data       (o_wb_data),
        .o_wb_wen        (o_wb_wen),
        .o_branch        (o_branch),
        .o_branch_target (o_branch_target)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // mode 1 arith, 2 logic, 3 branch/jump, anything else all ops
    function automatic exec_op_e pick_op(input int mode);
        logic [3:0] r;
        case (mode)
            1: begin
                r = 4'(rand_bits(2));
                return (r == 1) ? OP_SLT : (r == 2) ? OP_CMP : OP_ADD;
            end
            2: begin
                r = 4'(rand_bits(2));
                return (r == 0) ? OP_AND : (r == 1) ? OP_OR : (r == 2) ? OP_XOR : OP_SLA;
            end
            3: begin
                r = 4'(rand_bits(2));
                return (r == 2) ? OP_JAL : (r == 3) ? OP_JALR : OP_BRANCH;
            end
            default: begin
                r = 4'(rand_bits(4));
                return exec_op_e'(r % 4'd10);
            end
        endcase
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // draw one issue, drive it and work out its writeback from the op rules
    task automatic drive_issue(input int mode);
        exec_op_e  op;
        xlen_t     op1, op2, pc_r, pc_w, off, op2i, sum;
        reg_addr_t rd;
        logic      valid, sub, uns, cmp_mode, beq, binv, word, inv, lt, eq, taken;
        sll_t      sll;
        // mode 0 idles, mode 4 holds valid, the rest issue about 3 in 4 cycles
        valid    = (mode == 4) ? 1'b1 : (mode == 0) ? 1'b0 : (rand_bits(2) != 0);
        op       = pick_op(mode);
        op1      = rand_bits(64);
        // equal operands one time in four so eq branches get taken
        op2      = (rand_bits(2) == 0) ? op1 : rand_bits(64);
        pc_r     = rand_bits(64);
        pc_w     = pc_r + 64'd4;
        off      = rand_bits(64);
        rd       = (rand_bits(3) == 0) ? reg_addr_t'(0) : reg_addr_t'(rand_bits(5));
        sub      = 1'(rand_bits(1));
        uns      = 1'(rand_bits(1));
        cmp_mode = 1'(rand_bits(1));
        beq      = 1'(rand_bits(1));
        binv     = 1'(rand_bits(1));
        word     = 1'(rand_bits(1));
        inv      = 1'(rand_bits(1));
        sll      = sll_t'(rand_bits(2));
        // jumps are decoded as an always-true equal compare
        if (op == OP_JAL || op == OP_JALR) begin
            op2  = op1;
            beq  = 1'b1;
            binv = 1'b0;
        end
        // reads hit the write due on the next edge one time in four
        rs1_new = (rand_bits(2) == 0) ? p_rd[1] : reg_addr_t'(rand_bits(5));
        rs2_new = (rand_bits(2) == 0) ? p_rd[1] : reg_addr_t'(rand_bits(5));

        i_valid         <= valid;
        i_op            <= op;
        i_op1           <= op1;
        i_op2           <= op2;
        i_rd            <= rd;
        i_pc_rdata      <= pc_r;
        i_pc_wdata      <= pc_w;
        i_branch_offset <= off;
        i_sub           <= sub;
        i_unsigned      <= uns;
        i_cmp_mode      <= cmp_mode;
        i_branch_equal  <= beq;
        i_branch_invert <= binv;
        i_word          <= word;
        i_invert        <= inv;
        i_sll           <= sll;
        i_rs1_addr      <= rs1_new;
        i_rs2_addr      <= rs2_new;

        lt    = uns ? (op1 < op2) : ($signed(op1) < $signed(op2));
        eq    = (op1 == op2);
        taken = (beq ? eq : lt) ^ binv;
        op2i  = inv ? ~op2 : op2;

        e_valid  = valid;
        e_wen    = valid;
        e_rd     = rd;
        e_data   = '0;
        e_branch = 1'b0;
        e_target = '0;
        e_is_br  = 1'b0;
        if (op_is_logic(op)) begin
            case (op)
                OP_AND:  e_data = op1 & op2i;
                OP_OR:   e_data = op1 | op2i;
                OP_XOR:  e_data = op1 ^ op2i;
                default: e_data = (op1 << sll) + op2;
            endcase
        end else if (op_is_arith(op)) begin
            case (op)
                OP_ADD: begin
                    sum    = sub ? (op1 - op2) : (op1 + op2);
                    e_data = word ? {{32{sum[31]}}, sum[31:0]} : sum;
                end
                OP_SLT: e_data = {63'd0, lt};
                // min keeps the smaller, max the larger
                OP_CMP: e_data = (cmp_mode ? lt : !lt) ? op1 : op2;
                OP_BRANCH: begin
                    e_wen    = 1'b0;
                    e_is_br  = 1'b1;
                    e_branch = valid && taken;
                    e_target = taken ? (pc_r + off) : pc_w;
                end
                default: begin
                    e_data   = pc_w;
                    e_is_br  = 1'b1;
                    e_branch = valid && taken;
                    e_target = (op == OP_JALR) ? ((op1 + op2) & ~64'd1) : (op1 + op2);
                end
            endcase
        end
    endtask

    // runs at the falling edge, where all DUT outputs are settled
    task automatic compare_outputs();
        // the write the DUT did on the last rising edge, register 0 never changes
        if (wr_pend_en && wr_pend_rd != '0) begin
            model_regs[wr_pend_rd] = wr_pend_data;
        end
        check(o_rs1_rdata, model_regs[rs1_prev], "rs1 read data");
        check(o_rs2_rdata, model_regs[rs2_prev], "rs2 read data");
        check(o_wb_valid, p_valid[1], "wb valid");
        check(o_wb_wen, p_valid[1] && p_wen[1], "wb write enable");
        check(o_branch, p_branch[1], "branch taken");
        if (p_valid[1] && p_wen[1]) begin
            check(o_wb_data, p_data[1], "wb data");
            check(o_wb_rd, p_rd[1], "wb rd");
        end
        if (p_valid[1] && p_is_br[1]) begin
            check(o_branch_target, p_target[1], "branch target");
        end
        wr_pend_en   = p_valid[1] && p_wen[1];
        wr_pend_rd   = p_rd[1];
        wr_pend_data = p_data[1];
        p_valid[1]   = p_valid[0];
        p_wen[1]     = p_wen[0];
        p_branch[1]  = p_branch[0];
        p_is_br[1]   = p_is_br[0];
        p_rd[1]      = p_rd[0];
        p_data[1]    = p_data[0];
        p_target[1]  = p_target[0];
        p_valid[0]   = e_valid;
        p_wen[0]     = e_wen;
        p_branch[0]  = e_branch;
        p_is_br[0]   = e_is_br;
        p_rd[0]      = e_rd;
        p_data[0]    = e_data;
        p_target[0]  = e_target;
        rs1_prev     = rs1_new;
        rs2_prev     = rs2_new;
    endtask

    task automatic run_cycle(input int mode);
        @(posedge i_clk);
        drive_issue(mode);
        @(negedge i_clk);
        compare_outputs();
    endtask

    // idle cycles at the end let the test's last results drain out
    task automatic run_test(input string name, input int mode, input int n);
        int checks_before;
        int errors_before;
        checks_before = checks;
        errors_before = errors;
        repeat (n) run_cycle(mode);
        repeat (DRAIN_CYCLES) run_cycle(0);
        tests++;
        $display("test %-8s %0d checks, %0d errors", name, checks - checks_before,
                 errors - errors_before);
    endtask

    initial begin
        i_clk           = 1'b0;
        i_rst_n         = 1'b0;
        i_valid         = 1'b0;
        i_op            = OP_ADD;
        i_op1           = '0;
        i_op2           = '0;
        i_rd            = '0;
        i_pc_rdata      = '0;
        i_pc_wdata      = '0;
        i_branch_offset = '0;
        i_sub           = 1'b0;
        i_unsigned      = 1'b0;
        i_cmp_mode      = 1'b0;
        i_branch_equal  = 1'b0;
        i_branch_invert = 1'b0;
        i_word          = 1'b0;
        i_invert        = 1'b0;
        i_sll           = '0;
        i_rs1_addr      = '0;
        i_rs2_addr      = '0;
        lfsr            = 32'h21a8_3ba3;
        checks          = 0;
        errors          = 0;
        tests           = 0;
        wr_pend_en      = 1'b0;
        wr_pend_rd      = '0;
        wr_pend_data    = '0;
        rs1_new         = '0;
        rs2_new         = '0;
        rs1_prev        = '0;
        rs2_prev        = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        // empty pipe matches the cleared writeback registers
        for (int i = 0; i < 2; i++) begin
            p_valid[i]  = 1'b0;
            p_wen[i]    = 1'b0;
            p_branch[i] = 1'b0;
            p_is_br[i]  = 1'b0;
            p_rd[i]     = '0;
            p_data[i]   = '0;
            p_target[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;

        run_test("reset", 0, N_IDLE);
        run_test("arith", 1, N_ARITH);
        run_test("logic", 2, N_LOGIC);
        run_test("branch", 3, N_BRANCH);
        run_test("b2b", 4, N_B2B);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // ends a run that stalls past its expected length
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/int_exec_pkg.sv
verilog/int_arith.sv
verilog/int_logic.sv
verilog/int_writeback.sv
verilog/int_regfile.sv
verilog/int_exec_top.sv
dv/tb_int_exec.sv

/* Bender.yml */
package:
  name: int_exec

sources:
  - files:
      - verilog/int_exec_pkg.sv
      - verilog/int_arith.sv
      - verilog/int_logic.sv
      - verilog/int_writeback.sv
      - verilog/int_regfile.sv
      - verilog/int_exec_top.sv
  - target: test
    files:
      - dv/tb_int_exec.sv
